// ==== Makefile ====
# Verilator build and run of the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_subsys_main
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: sim clean

# Fails unless the run prints the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
+incdir+src
src/subsys_pkg.sv
src/subsys_ppi_fabric.sv
src/subsys_clint.sv
src/subsys_gpio.sv
src/subsys_main.sv
verif/subsys_main_assert.sv
verif/tb_subsys_main.sv

// ==== src/subsys_clint.sv ====
// Core-local interruptor
// msip, mtime and mtimecmp registers with byte-masked writes
// RTC toggle synchronizer, edge detect and interrupt outputs
`timescale 1ns/1ps
`include "subsys_defs.svh"

module subsys_clint
  import subsys_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   cmd_valid,
  input  addr_t  addr,
  input  logic   read,
  input  data_t  wdata,
  input  wmask_t wmask,
  input  logic   rtc_toggle,
  input  logic   tm_stop,
  output logic   rsp_valid,
  output logic   rsp_err,
  output data_t  rsp_rdata,
  output logic   sft_irq,
  output logic   tmr_irq
);

  logic [`SUBSYS_CLINT_SIZE_LOG2-1:0] ofs;
  logic   hit;
  logic   wr_en;
  data_t  rd_val;
  logic [1:0] rtc_sync;
  logic   rtc_dly;
  logic   rtc_rise;
  logic   msip_q;
  mtime_t mtime_q;
  mtime_t mtime_nxt;
  mtime_t mtimecmp_q;

  assign ofs   = addr[`SUBSYS_CLINT_SIZE_LOG2-1:0];
  assign wr_en = cmd_valid & ~read & hit;

  ////////////////////////////////////////////////////////////////////
  // RTC toggle crossing

  // Two flops into hclk, then one more for the edge
  always_ff @(posedge clk) begin
    if (rst) begin
      rtc_sync <= '0;
      rtc_dly  <= 1'b0;
    end else begin
      rtc_sync <= {rtc_sync[0], rtc_toggle};
      rtc_dly  <= rtc_sync[1];
    end
  end

  assign rtc_rise = rtc_sync[1] & ~rtc_dly;

  ////////////////////////////////////////////////////////////////////
  // Register file

  always_comb begin
    hit    = 1'b1;
    rd_val = '0;
    case (ofs)
      `CLINT_MSIP_OFS:        rd_val = data_t'(msip_q);
      `CLINT_MTIMECMP_LO_OFS: rd_val = mtimecmp_q[31:0];
      `CLINT_MTIMECMP_HI_OFS: rd_val = mtimecmp_q[63:32];
      `CLINT_MTIME_LO_OFS:    rd_val = mtime_q[31:0];
      `CLINT_MTIME_HI_OFS:    rd_val = mtime_q[63:32];
      default:                hit    = 1'b0;
    endcase
  end

  // Software writes win over the tick
  always_comb begin
    mtime_nxt = mtime_q;
    if (rtc_rise && !tm_stop) begin
      mtime_nxt = mtime_q + 64'd1;
    end
    if (wr_en && ofs == `CLINT_MTIME_LO_OFS) begin
      mtime_nxt[31:0] = mask_merge(mtime_q[31:0], wdata, wmask);
    end
    if (wr_en && ofs == `CLINT_MTIME_HI_OFS) begin
      mtime_nxt[63:32] = mask_merge(mtime_q[63:32], wdata, wmask);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      msip_q     <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      mtime_q <= mtime_nxt;
      // Only bit 0 of msip exists
      if (wr_en && ofs == `CLINT_MSIP_OFS && wmask[0]) begin
        msip_q <= wdata[0];
      end
      if (wr_en && ofs == `CLINT_MTIMECMP_LO_OFS) begin
        mtimecmp_q[31:0] <= mask_merge(mtimecmp_q[31:0], wdata, wmask);
      end
      if (wr_en && ofs == `CLINT_MTIMECMP_HI_OFS) begin
        mtimecmp_q[63:32] <= mask_merge(mtimecmp_q[63:32], wdata, wmask);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Response and interrupts

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= cmd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      rsp_err   <= ~hit;
      rsp_rdata <= rd_val;
    end
  end

  assign sft_irq = msip_q;
  assign tmr_irq = (mtime_q >= mtimecmp_q);

endmodule

// ==== src/subsys_defs.svh ====
// Subsystem width macros
// Peripheral region bases and sizes
// CLINT and GPIO register offsets
`ifndef SUBSYS_DEFS_SVH
`define SUBSYS_DEFS_SVH

// Bus and pad widths
`define SUBSYS_ADDR_W          32
`define SUBSYS_XLEN            32
`define SUBSYS_GPIO_W          32

// Region map
`define SUBSYS_CLINT_BASE      32'h0200_0000
`define SUBSYS_CLINT_SIZE_LOG2 16
`define SUBSYS_GPIO_BASE       32'h1001_2000
`define SUBSYS_GPIO_SIZE_LOG2  12

// CLINT offsets within its 64 KB window
`define CLINT_MSIP_OFS         16'h0000
`define CLINT_MTIMECMP_LO_OFS  16'h4000
`define CLINT_MTIMECMP_HI_OFS  16'h4004
`define CLINT_MTIME_LO_OFS     16'hBFF8
`define CLINT_MTIME_HI_OFS     16'hBFFC

// GPIO offsets within its 4 KB window
`define GPIO_INPUT_VAL_OFS     12'h000
`define GPIO_OUTPUT_EN_OFS     12'h008
`define GPIO_OUTPUT_VAL_OFS    12'h00C
`define GPIO_RISE_IE_OFS       12'h018
`define GPIO_RISE_IP_OFS       12'h01C

`endif

// ==== src/subsys_gpio.sv ====
// GPIO block with 32 pads
// Output value and enable, synchronized input value
// Rising-edge interrupt enable and pending registers
`timescale 1ns/1ps
`include "subsys_defs.svh"

module subsys_gpio
  import subsys_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      cmd_valid,
  input  addr_t     addr,
  input  logic      read,
  input  data_t     wdata,
  input  wmask_t    wmask,
  input  gpio_vec_t pad_in,
  output logic      rsp_valid,
  output logic      rsp_err,
  output data_t     rsp_rdata,
  output gpio_vec_t pad_out,
  output gpio_vec_t pad_oe,
  output logic      irq
);

  logic [`SUBSYS_GPIO_SIZE_LOG2-1:0] ofs;
  logic      hit;
  logic      wr_en;
  data_t     rd_val;
  gpio_vec_t in_s1;
  gpio_vec_t in_val;
  gpio_vec_t in_dly;
  gpio_vec_t rise;
  gpio_vec_t ip_clr;
  gpio_vec_t out_val_q;
  gpio_vec_t out_en_q;
  gpio_vec_t rise_ie_q;
  gpio_vec_t rise_ip_q;

  assign ofs   = addr[`SUBSYS_GPIO_SIZE_LOG2-1:0];
  assign wr_en = cmd_valid & ~read & hit;

  ////////////////////////////////////////////////////////////////////
  // Pad input path

  always_ff @(posedge clk) begin
    if (rst) begin
      in_s1  <= '0;
      in_val <= '0;
      in_dly <= '0;
    end else begin
      in_s1  <= pad_in;
      in_val <= in_s1;
      in_dly <= in_val;
    end
  end

  assign rise = in_val & ~in_dly;

  ////////////////////////////////////////////////////////////////////
  // Registers

  always_comb begin
    hit    = 1'b1;
    rd_val = '0;
    case (ofs)
      `GPIO_INPUT_VAL_OFS:  rd_val = in_val;
      `GPIO_OUTPUT_EN_OFS:  rd_val = out_en_q;
      `GPIO_OUTPUT_VAL_OFS: rd_val = out_val_q;
      `GPIO_RISE_IE_OFS:    rd_val = rise_ie_q;
      `GPIO_RISE_IP_OFS:    rd_val = rise_ip_q;
      default:              hit    = 1'b0;
    endcase
  end

  // Write one to clear, masked by byte enables
  assign ip_clr = (wr_en && ofs == `GPIO_RISE_IP_OFS) ?
                  mask_merge('0, wdata, wmask) : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_val_q <= '0;
      out_en_q  <= '0;
      rise_ie_q <= '0;
      rise_ip_q <= '0;
    end else begin
      if (wr_en && ofs == `GPIO_OUTPUT_EN_OFS) begin
        out_en_q <= mask_merge(out_en_q, wdata, wmask);
      end
      if (wr_en && ofs == `GPIO_OUTPUT_VAL_OFS) begin
        out_val_q <= mask_merge(out_val_q, wdata, wmask);
      end
      if (wr_en && ofs == `GPIO_RISE_IE_OFS) begin
        rise_ie_q <= mask_merge(rise_ie_q, wdata, wmask);
      end
      // New edge beats a clear in the same cycle
      rise_ip_q <= (rise_ip_q & ~ip_clr) | rise;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Response and outputs

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= cmd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      rsp_err   <= ~hit;
      rsp_rdata <= rd_val;
    end
  end

  assign pad_out = out_val_q;
  assign pad_oe  = out_en_q;
  assign irq     = |(rise_ip_q & rise_ie_q);

endmodule

// ==== src/subsys_main.sv ====
// Subsystem top
// Peripheral bus fabric with the CLINT and GPIO devices
`timescale 1ns/1ps

module subsys_main
  import subsys_pkg::*;
(
  input  logic      hfclk,
  input  logic      rst,
  // Private peripheral ICB
  input  logic      ppi_icb_cmd_valid,
  output logic      ppi_icb_cmd_ready,
  input  addr_t     ppi_icb_cmd_addr,
  input  logic      ppi_icb_cmd_read,
  input  data_t     ppi_icb_cmd_wdata,
  input  wmask_t    ppi_icb_cmd_wmask,
  output logic      ppi_icb_rsp_valid,
  input  logic      ppi_icb_rsp_ready,
  output logic      ppi_icb_rsp_err,
  output data_t     ppi_icb_rsp_rdata,
  // Timer inputs
  input  logic      aon_rtc_toggle,
  input  logic      tm_stop,
  // Pads
  input  gpio_vec_t gpio_pad_in,
  output gpio_vec_t gpio_pad_out,
  output gpio_vec_t gpio_pad_oe,
  // Interrupts
  output logic      clint_sft_irq,
  output logic      clint_tmr_irq,
  output logic      gpio_irq
);

  logic   clint_cmd_valid;
  logic   gpio_cmd_valid;
  addr_t  dev_addr;
  logic   dev_read;
  data_t  dev_wdata;
  wmask_t dev_wmask;
  logic   clint_rsp_valid;
  logic   clint_rsp_err;
  data_t  clint_rsp_rdata;
  logic   gpio_rsp_valid;
  logic   gpio_rsp_err;
  data_t  gpio_rsp_rdata;

  subsys_ppi_fabric i_fabric (
    .clk             (hfclk),
    .rst             (rst),
    .cmd_valid       (ppi_icb_cmd_valid),
    .cmd_ready       (ppi_icb_cmd_ready),
    .cmd_addr        (ppi_icb_cmd_addr),
    .cmd_read        (ppi_icb_cmd_read),
    .cmd_wdata       (ppi_icb_cmd_wdata),
    .cmd_wmask       (ppi_icb_cmd_wmask),
    .rsp_valid       (ppi_icb_rsp_valid),
    .rsp_ready       (ppi_icb_rsp_ready),
    .rsp_err         (ppi_icb_rsp_err),
    .rsp_rdata       (ppi_icb_rsp_rdata),
    .clint_cmd_valid (clint_cmd_valid),
    .gpio_cmd_valid  (gpio_cmd_valid),
    .dev_addr        (dev_addr),
    .dev_read        (dev_read),
    .dev_wdata       (dev_wdata),
    .dev_wmask       (dev_wmask),
    .clint_rsp_valid (clint_rsp_valid),
    .clint_rsp_err   (clint_rsp_err),
    .clint_rsp_rdata (clint_rsp_rdata),
    .gpio_rsp_valid  (gpio_rsp_valid),
    .gpio_rsp_err    (gpio_rsp_err),
    .gpio_rsp_rdata  (gpio_rsp_rdata)
  );

  subsys_clint i_clint (
    .clk        (hfclk),
    .rst        (rst),
    .cmd_valid  (clint_cmd_valid),
    .addr       (dev_addr),
    .read       (dev_read),
    .wdata      (dev_wdata),
    .wmask      (dev_wmask),
    .rtc_toggle (aon_rtc_toggle),
    .tm_stop    (tm_stop),
    .rsp_valid  (clint_rsp_valid),
    .rsp_err    (clint_rsp_err),
    .rsp_rdata  (clint_rsp_rdata),
    .sft_irq    (clint_sft_irq),
    .tmr_irq    (clint_tmr_irq)
  );

  subsys_gpio i_gpio (
    .clk       (hfclk),
    .rst       (rst),
    .cmd_valid (gpio_cmd_valid),
    .addr      (dev_addr),
    .read      (dev_read),
    .wdata     (dev_wdata),
    .wmask     (dev_wmask),
    .pad_in    (gpio_pad_in),
    .rsp_valid (gpio_rsp_valid),
    .rsp_err   (gpio_rsp_err),
    .rsp_rdata (gpio_rsp_rdata),
    .pad_out   (gpio_pad_out),
    .pad_oe    (gpio_pad_oe),
    .irq       (gpio_irq)
  );

endmodule

// ==== src/subsys_pkg.sv ====
// Subsystem package
// Bus, pad and timer vector types, fabric state enums
// Byte-masked register merge shared by the devices
`include "subsys_defs.svh"

package subsys_pkg;

  typedef logic [`SUBSYS_ADDR_W-1:0]   addr_t;
  typedef logic [`SUBSYS_XLEN-1:0]     data_t;
  typedef logic [`SUBSYS_XLEN/8-1:0]   wmask_t;
  typedef logic [`SUBSYS_GPIO_W-1:0]   gpio_vec_t;
  typedef logic [63:0]                 mtime_t;

  // Fabric sequencing, one transaction at a time
  typedef enum logic [1:0] {PPI_IDLE, PPI_WAIT, PPI_RESP} ppi_state_e;

  // Device that owes the pending response
  typedef enum logic [1:0] {TGT_CLINT, TGT_GPIO, TGT_NONE} ppi_tgt_e;

  // Replace only the bytes selected by the write mask
  function automatic data_t mask_merge(data_t old_val, data_t new_val, wmask_t wmask);
    data_t res;
    res = old_val;
    for (int i = 0; i < `SUBSYS_XLEN/8; i++) begin
      if (wmask[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

// ==== src/subsys_ppi_fabric.sv ====
// Private peripheral bus fabric
// Region decode, device command pulse, held response and back-pressure
`timescale 1ns/1ps
`include "subsys_defs.svh"

module subsys_ppi_fabric
  import subsys_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  // Upstream ICB
  input  logic   cmd_valid,
  output logic   cmd_ready,
  input  addr_t  cmd_addr,
  input  logic   cmd_read,
  input  data_t  cmd_wdata,
  input  wmask_t cmd_wmask,
  output logic   rsp_valid,
  input  logic   rsp_ready,
  output logic   rsp_err,
  output data_t  rsp_rdata,
  // Device command side
  output logic   clint_cmd_valid,
  output logic   gpio_cmd_valid,
  output addr_t  dev_addr,
  output logic   dev_read,
  output data_t  dev_wdata,
  output wmask_t dev_wmask,
  // Device response side
  input  logic   clint_rsp_valid,
  input  logic   clint_rsp_err,
  input  data_t  clint_rsp_rdata,
  input  logic   gpio_rsp_valid,
  input  logic   gpio_rsp_err,
  input  data_t  gpio_rsp_rdata
);

  ppi_state_e state_q;
  ppi_tgt_e   tgt_q;
  ppi_tgt_e   tgt_dec;
  logic       cmd_accept;
  logic       rsp_take;
  logic       dev_done;
  logic       sel_err;
  data_t      sel_rdata;
  logic       rsp_err_q;
  data_t      rsp_rdata_q;

  ////////////////////////////////////////////////////////////////////
  // Decode and command forwarding

  always_comb begin
    if ((cmd_addr >> `SUBSYS_CLINT_SIZE_LOG2) ==
        (addr_t'(`SUBSYS_CLINT_BASE) >> `SUBSYS_CLINT_SIZE_LOG2)) begin
      tgt_dec = TGT_CLINT;
    end else if ((cmd_addr >> `SUBSYS_GPIO_SIZE_LOG2) ==
                 (addr_t'(`SUBSYS_GPIO_BASE) >> `SUBSYS_GPIO_SIZE_LOG2)) begin
      tgt_dec = TGT_GPIO;
    end else begin
      tgt_dec = TGT_NONE;
    end
  end

  // Only accepted while idle, so the devices never stall
  assign cmd_ready  = (state_q == PPI_IDLE);
  assign cmd_accept = cmd_valid & cmd_ready;

  assign clint_cmd_valid = cmd_accept & (tgt_dec == TGT_CLINT);
  assign gpio_cmd_valid  = cmd_accept & (tgt_dec == TGT_GPIO);
  assign dev_addr  = cmd_addr;
  assign dev_read  = cmd_read;
  assign dev_wdata = cmd_wdata;
  assign dev_wmask = cmd_wmask;

  ////////////////////////////////////////////////////////////////////
  // Response selection and hold

  always_comb begin
    dev_done  = 1'b0;
    sel_err   = 1'b1;
    sel_rdata = '0;
    case (tgt_q)
      TGT_CLINT: begin
        dev_done  = clint_rsp_valid;
        sel_err   = clint_rsp_err;
        sel_rdata = clint_rsp_rdata;
      end
      TGT_GPIO: begin
        dev_done  = gpio_rsp_valid;
        sel_err   = gpio_rsp_err;
        sel_rdata = gpio_rsp_rdata;
      end
      // Unmapped address answered by the fabric itself
      default: dev_done = 1'b1;
    endcase
  end

  assign rsp_valid = (state_q == PPI_RESP);
  assign rsp_take  = rsp_valid & rsp_ready;
  assign rsp_err   = rsp_err_q;
  assign rsp_rdata = rsp_rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= PPI_IDLE;
      tgt_q   <= TGT_NONE;
    end else begin
      case (state_q)
        PPI_IDLE: begin
          if (cmd_accept) begin
            state_q <= PPI_WAIT;
            tgt_q   <= tgt_dec;
          end
        end
        PPI_WAIT: begin
          if (dev_done) begin
            state_q <= PPI_RESP;
          end
        end
        PPI_RESP: begin
          if (rsp_take) begin
            state_q <= PPI_IDLE;
          end
        end
        default: state_q <= PPI_IDLE;
      endcase
    end
  end

  // Held until the upstream takes it
  always_ff @(posedge clk) begin
    if (state_q == PPI_WAIT && dev_done) begin
      rsp_err_q   <= sel_err;
      rsp_rdata_q <= sel_rdata;
    end
  end

endmodule

// ==== verif/subsys_main_assert.sv ====
// ICB protocol checks on the subsystem top
// Bound into subsys_main
`timescale 1ns/1ps

module subsys_main_assert
  import subsys_pkg::*;
(
  input logic  clk,
  input logic  rst,
  input logic  cmd_valid,
  input logic  cmd_ready,
  input logic  rsp_valid,
  input logic  rsp_ready,
  input logic  rsp_err,
  input data_t rsp_rdata
);

  logic accept;
  // Failed property count
  int   fail_count = 0;

  assign accept = cmd_valid & cmd_ready;

  // Single outstanding transaction
  a_ready_blocked: assert property (@(posedge clk) disable iff (rst)
    rsp_valid |-> !cmd_ready)
    else begin
      fail_count++;
      $error("cmd_ready high while a response is pending");
    end

  // Held response under back-pressure
  a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_err) && $stable(rsp_rdata))
    else begin
      fail_count++;
      $error("response changed or dropped before rsp_ready");
    end

  a_rsp_latency: assert property (@(posedge clk) disable iff (rst)
    $past(accept, 2) |-> $rose(rsp_valid))
    else begin
      fail_count++;
      $error("rsp_valid did not rise two cycles after the accept");
    end

  // Every response traces back to an accept
  a_rsp_origin: assert property (@(posedge clk) disable iff (rst)
    $rose(rsp_valid) |-> $past(accept, 2))
    else begin
      fail_count++;
      $error("response appeared without a matching accept");
    end

endmodule

bind subsys_main subsys_main_assert i_assert (
  .clk       (hfclk),
  .rst       (rst),
  .cmd_valid (ppi_icb_cmd_valid),
  .cmd_ready (ppi_icb_cmd_ready),
  .rsp_valid (ppi_icb_rsp_valid),
  .rsp_ready (ppi_icb_rsp_ready),
  .rsp_err   (ppi_icb_rsp_err),
  .rsp_rdata (ppi_icb_rsp_rdata)
);

// ==== verif/tb_subsys_main.sv ====
// Testbench for the peripheral subsystem top
// Bus tasks, directed and random register checks
// Watchdog and closing report
`timescale 1ns/1ps
`include "subsys_defs.svh"

module tb_subsys_main
  import subsys_pkg::*;
();

  localparam int WATCHDOG_CYCLES = 20000;
  localparam int WAIT_LIMIT      = 64;

  localparam addr_t MSIP_A        = `SUBSYS_CLINT_BASE + addr_t'(`CLINT_MSIP_OFS);
  localparam addr_t MTIMECMP_LO_A = `SUBSYS_CLINT_BASE + addr_t'(`CLINT_MTIMECMP_LO_OFS);
  localparam addr_t MTIMECMP_HI_A = `SUBSYS_CLINT_BASE + addr_t'(`CLINT_MTIMECMP_HI_OFS);
  localparam addr_t MTIME_LO_A    = `SUBSYS_CLINT_BASE + addr_t'(`CLINT_MTIME_LO_OFS);
  localparam addr_t MTIME_HI_A    = `SUBSYS_CLINT_BASE + addr_t'(`CLINT_MTIME_HI_OFS);
  localparam addr_t CLINT_BAD_A   = `SUBSYS_CLINT_BASE + 32'h0000_0010;
  localparam addr_t IN_VAL_A      = `SUBSYS_GPIO_BASE + addr_t'(`GPIO_INPUT_VAL_OFS);
  localparam addr_t OUT_EN_A      = `SUBSYS_GPIO_BASE + addr_t'(`GPIO_OUTPUT_EN_OFS);
  localparam addr_t OUT_VAL_A     = `SUBSYS_GPIO_BASE + addr_t'(`GPIO_OUTPUT_VAL_OFS);
  localparam addr_t RISE_IE_A     = `SUBSYS_GPIO_BASE + addr_t'(`GPIO_RISE_IE_OFS);
  localparam addr_t RISE_IP_A     = `SUBSYS_GPIO_BASE + addr_t'(`GPIO_RISE_IP_OFS);
  localparam addr_t GPIO_BAD_A    = `SUBSYS_GPIO_BASE + 32'h0000_0004;
  localparam addr_t UNMAPPED_A    = 32'h3000_0000;

  logic      hfclk;
  logic      rst;
  logic      cmd_valid;
  logic      cmd_ready;
  addr_t     cmd_addr;
  logic      cmd_read;
  data_t     cmd_wdata;
  wmask_t    cmd_wmask;
  logic      rsp_valid;
  logic      rsp_ready;
  logic      rsp_err;
  data_t     rsp_rdata;
  logic      rtc_toggle;
  logic      tm_stop;
  gpio_vec_t pad_in;
  gpio_vec_t pad_out;
  gpio_vec_t pad_oe;
  logic      sft_irq;
  logic      tmr_irq;
  logic      gpio_irq;

  int        errors;
  int        checks;
  int        bp_max;
  int        k;
  gpio_vec_t exp_oe;
  gpio_vec_t exp_out;
  gpio_vec_t pins;
  data_t     d;
  data_t     rd;
  wmask_t    m;
  logic      e;

  subsys_main i_subsys_main (
    .hfclk             (hfclk),
    .rst               (rst),
    .ppi_icb_cmd_valid (cmd_valid),
    .ppi_icb_cmd_ready (cmd_ready),
    .ppi_icb_cmd_addr  (cmd_addr),
    .ppi_icb_cmd_read  (cmd_read),
    .ppi_icb_cmd_wdata (cmd_wdata),
    .ppi_icb_cmd_wmask (cmd_wmask),
    .ppi_icb_rsp_valid (rsp_valid),
    .ppi_icb_rsp_ready (rsp_ready),
    .ppi_icb_rsp_err   (rsp_err),
    .ppi_icb_rsp_rdata (rsp_rdata),
    .aon_rtc_toggle    (rtc_toggle),
    .tm_stop           (tm_stop),
    .gpio_pad_in       (pad_in),
    .gpio_pad_out      (pad_out),
    .gpio_pad_oe       (pad_oe),
    .clint_sft_irq     (sft_irq),
    .clint_tmr_irq     (tmr_irq),
    .gpio_irq          (gpio_irq)
  );

  initial begin
    hfclk = 1'b0;
    forever #5 hfclk = ~hfclk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers

  // All driving and sampling happens 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge hfclk);
    #1;
  endtask

  // Expected register after a byte-masked write
  function automatic data_t merge_bytes(data_t old_val, data_t new_val, wmask_t mask);
    data_t keep;
    keep = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (old_val & ~keep) | (new_val & keep);
  endfunction

  task automatic check_value(input string name, input data_t exp, input data_t act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // One ICB transaction with random response back-pressure
  task automatic bus_xfer(input addr_t addr, input logic rd_en, input data_t wdata,
                          input wmask_t wmask, output logic err, output data_t rdata);
    int waited;
    int hold;
    err       = 1'b1;
    rdata     = '0;
    cmd_valid = 1'b1;
    cmd_addr  = addr;
    cmd_read  = rd_en;
    cmd_wdata = wdata;
    cmd_wmask = wmask;
    waited    = 0;
    while (!cmd_ready && waited < WAIT_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (!cmd_ready) begin
      errors++;
      $display("Timeout: cmd_ready stayed low for a command to %h", addr);
      cmd_valid = 1'b0;
      return;
    end
    next_cycle();
    cmd_valid = 1'b0;
    waited    = 0;
    while (!rsp_valid && waited < WAIT_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (!rsp_valid) begin
      errors++;
      $display("Timeout: no response arrived for the command to %h", addr);
      return;
    end
    hold = $urandom_range(bp_max, 0);
    repeat (hold) begin
      check_bit("cmd_ready under back-pressure", 1'b0, cmd_ready);
      next_cycle();
    end
    rsp_ready = 1'b1;
    err       = rsp_err;
    rdata     = rsp_rdata;
    next_cycle();
    rsp_ready = 1'b0;
    check_bit("cmd_ready after response", 1'b1, cmd_ready);
  endtask

  task automatic bus_write(input addr_t addr, input data_t wdata, input wmask_t wmask,
                           output logic err);
    data_t unused_rdata;
    bus_xfer(addr, 1'b0, wdata, wmask, err, unused_rdata);
  endtask

  task automatic bus_read(input addr_t addr, output data_t rdata, output logic err);
    bus_xfer(addr, 1'b1, '0, 4'h0, err, rdata);
  endtask

  task automatic write_check(input string name, input addr_t addr, input data_t wdata,
                             input wmask_t wmask);
    logic err;
    bus_write(addr, wdata, wmask, err);
    check_bit({name, " err"}, 1'b0, err);
  endtask

  task automatic read_check(input string name, input addr_t addr, input data_t exp);
    logic  err;
    data_t rdata;
    bus_read(addr, rdata, err);
    check_bit({name, " err"}, 1'b0, err);
    check_value(name, exp, rdata);
  endtask

  // One RTC rising edge held long enough for the synchronizer
  task automatic rtc_edge();
    rtc_toggle = 1'b1;
    repeat (4) next_cycle();
    rtc_toggle = 1'b0;
    repeat (4) next_cycle();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    void'($urandom(35919));
    rst        = 1'b1;
    cmd_valid  = 1'b0;
    cmd_addr   = '0;
    cmd_read   = 1'b0;
    cmd_wdata  = '0;
    cmd_wmask  = '0;
    rsp_ready  = 1'b0;
    rtc_toggle = 1'b0;
    tm_stop    = 1'b0;
    pad_in     = '0;
    errors     = 0;
    checks     = 0;
    bp_max     = 1;
    exp_oe     = '0;
    exp_out    = '0;
    repeat (8) @(posedge hfclk);
    #1;
    rst = 1'b0;

    // Reset state
    check_bit("reset cmd_ready", 1'b1, cmd_ready);
    check_bit("reset rsp_valid", 1'b0, rsp_valid);
    check_bit("reset sft_irq", 1'b0, sft_irq);
    check_bit("reset tmr_irq", 1'b0, tmr_irq);
    check_bit("reset gpio_irq", 1'b0, gpio_irq);
    check_value("reset pad_oe", '0, pad_oe);
    read_check("reset mtimecmp lo", MTIMECMP_LO_A, 32'hFFFF_FFFF);
    read_check("reset mtimecmp hi", MTIMECMP_HI_A, 32'hFFFF_FFFF);

    // Software interrupt follows msip bit 0
    d = $urandom | 32'h1;
    write_check("msip set", MSIP_A, d, 4'hF);
    check_bit("msip set irq", 1'b1, sft_irq);
    read_check("msip set readback", MSIP_A, 32'h1);
    d = $urandom & ~32'h1;
    write_check("msip clear", MSIP_A, d, 4'hF);
    check_bit("msip clear irq", 1'b0, sft_irq);
    read_check("msip clear readback", MSIP_A, 32'h0);

    // Timer compare at 5 ticks
    write_check("mtimecmp hi", MTIMECMP_HI_A, 32'h0, 4'hF);
    write_check("mtimecmp lo", MTIMECMP_LO_A, 32'd5, 4'hF);
    for (int i = 1; i <= 5; i++) begin
      rtc_edge();
      if (i == 4) begin
        check_bit("timer irq after 4 edges", 1'b0, tmr_irq);
      end
    end
    check_bit("timer irq after 5 edges", 1'b1, tmr_irq);
    read_check("mtime lo", MTIME_LO_A, 32'd5);
    read_check("mtime hi", MTIME_HI_A, 32'd0);
    tm_stop = 1'b1;
    repeat (3) rtc_edge();
    read_check("mtime frozen", MTIME_LO_A, 32'd5);
    tm_stop = 1'b0;

    // GPIO outputs with random byte masks
    for (int i = 0; i < 3; i++) begin
      d = $urandom;
      m = wmask_t'($urandom);
      write_check("output_en", OUT_EN_A, d, m);
      exp_oe = merge_bytes(exp_oe, d, m);
      d = $urandom;
      m = wmask_t'($urandom);
      write_check("output_val", OUT_VAL_A, d, m);
      exp_out = merge_bytes(exp_out, d, m);
      check_value("pad_oe", exp_oe, pad_oe);
      check_value("pad_out", exp_out, pad_out);
    end
    read_check("output_en readback", OUT_EN_A, exp_oe);
    read_check("output_val readback", OUT_VAL_A, exp_out);
    pins   = $urandom;
    pad_in = pins;
    repeat (4) next_cycle();
    read_check("input_val", IN_VAL_A, pins);

    // Rise interrupt on one random pin
    k      = $urandom_range(31, 0);
    pins   = pins & ~(32'h1 << k);
    pad_in = pins;
    repeat (4) next_cycle();
    write_check("rise_ip clear all", RISE_IP_A, 32'hFFFF_FFFF, 4'hF);
    read_check("rise_ip cleared", RISE_IP_A, 32'h0);
    write_check("rise_ie", RISE_IE_A, 32'h1 << k, 4'hF);
    check_bit("gpio irq before rise", 1'b0, gpio_irq);
    pins   = pins | (32'h1 << k);
    pad_in = pins;
    repeat (4) next_cycle();
    check_bit("gpio irq after rise", 1'b1, gpio_irq);
    read_check("rise_ip after rise", RISE_IP_A, 32'h1 << k);
    write_check("rise_ip clear bit", RISE_IP_A, 32'h1 << k, 4'hF);
    check_bit("gpio irq after clear", 1'b0, gpio_irq);
    read_check("rise_ip after clear", RISE_IP_A, 32'h0);

    // Error responses
    bus_read(UNMAPPED_A, rd, e);
    check_bit("unmapped read err", 1'b1, e);
    check_value("unmapped read rdata", 32'h0, rd);
    bus_write(UNMAPPED_A, $urandom, 4'hF, e);
    check_bit("unmapped write err", 1'b1, e);
    bus_read(CLINT_BAD_A, rd, e);
    check_bit("clint bad offset err", 1'b1, e);
    check_value("clint bad offset rdata", 32'h0, rd);
    bus_read(GPIO_BAD_A, rd, e);
    check_bit("gpio bad offset err", 1'b1, e);
    check_value("gpio bad offset rdata", 32'h0, rd);

    // Longer back-pressure watched by the bound checks
    bp_max = 6;
    for (int i = 0; i < 8; i++) begin
      read_check("output_en under back-pressure", OUT_EN_A, exp_oe);
    end

    errors = errors + i_subsys_main.i_assert.fail_count;
    $display("Run ended: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge hfclk);
    $display("Watchdog expired after %0d cycles, the test sequence did not finish",
             WATCHDOG_CYCLES);
    $display("Run ended: %0d checks, %0d errors", checks, errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
